// ==== src/disp_defines.svh ====
`ifndef DISP_DEFINES_SVH
`define DISP_DEFINES_SVH

// word addresses seen on the core bus

// display word shown by the scanner
`define DISP_ADDR 32'h0000_0400

// board leds in the low half
`define LED_ADDR 32'h0000_0404

// read-only port for the five debug switches
`define SW_ADDR 32'h0000_0408

// hex digits on the board
`define NUM_DIGITS 8

// clk_5M cycles spent on each digit
// 5000 gives a 1 kHz digit rate
`define SCAN_DIV_DEFAULT 5000

`endif

// ==== src/disp_pkg.sv ====
`include "disp_defines.svh"

package disp_pkg;

  // core-side load/store request
  // one transfer per cycle and no back-pressure
  typedef struct packed {
    // store strobe for one cycle
    logic        wea;
    // load strobe with data valid the next cycle
    logic        rea;
    // byte lane enables
    // bit 0 covers din[7:0]
    logic [3:0]  en;
    // full byte address
    logic [31:0] addr;
    // store data
    logic [31:0] din;
  } mmio_req_t;

  // display word with two views of the same bits
  // bytes for lane writes from the bus
  // nibbles for picking the shown digit
  // nibble 0 is bits 3..0 and lights anode 0
  typedef union packed {
    logic [3:0][7:0]             bytes;
    logic [`NUM_DIGITS-1:0][3:0] nibbles;
  } disp_word_u;

endpackage

// ==== src/mmio_regs.sv ====
`timescale 1ns/1ns
`include "disp_defines.svh"

module mmio_regs (
  input  logic                 clk_5M,
  input  logic                 reset,
  input  disp_pkg::mmio_req_t  mmio_req,
  input  logic [4:0]           debug_input,
  output disp_pkg::disp_word_u disp_word,
  output logic [15:0]          led,
  output logic [31:0]          mem_dout
);
  import disp_pkg::*;

  // address hits
  logic        hit_disp;
  logic        hit_led;
  logic        hit_sw;
  // store data seen as byte lanes
  disp_word_u  wr_word;
  // value for the addressed register
  logic [31:0] rd_mux;

  assign wr_word  = mmio_req.din;

  // full 32-bit compare
  // anything else is unmapped
  assign hit_disp = (mmio_req.addr == `DISP_ADDR);
  assign hit_led  = (mmio_req.addr == `LED_ADDR);
  assign hit_sw   = (mmio_req.addr == `SW_ADDR);

  // display register
  // each enabled lane is taken at the store edge
  always_ff @(posedge clk_5M) begin
    if (reset) begin
      disp_word <= '0;
    end else if (mmio_req.wea && hit_disp) begin
      for (int i = 0; i < 4; i++) begin
        if (mmio_req.en[i]) begin
          disp_word.bytes[i] <= wr_word.bytes[i];
        end
      end
    end
  end

  // led register, 16 bits
  // only lanes 0 and 1 land here
  always_ff @(posedge clk_5M) begin
    if (reset) begin
      led <= '0;
    end else if (mmio_req.wea && hit_led) begin
      if (mmio_req.en[0]) begin
        led[7:0] <= wr_word.bytes[0];
      end
      if (mmio_req.en[1]) begin
        led[15:8] <= wr_word.bytes[1];
      end
    end
  end

  // read mux from the current register contents
  // a store in the same cycle is not visible yet
  always_comb begin
    rd_mux = '0;
    if (hit_disp) begin
      rd_mux = disp_word;
    end else if (hit_led) begin
      // zero-extended led word
      rd_mux = {16'h0000, led};
    end else if (hit_sw) begin
      // switches in the low bits
      rd_mux = {27'd0, debug_input};
    end
  end

  // load data register
  // holds until the next load
  always_ff @(posedge clk_5M) begin
    if (reset) begin
      mem_dout <= '0;
    end else if (mmio_req.rea) begin
      mem_dout <= rd_mux;
    end
  end

endmodule

// ==== src/refresh_timer.sv ====
`timescale 1ns/1ns
`include "disp_defines.svh"

module refresh_timer #(
  // cycles per digit, at least 2
  parameter int div_count = `SCAN_DIV_DEFAULT
) (
  input  logic clk_5M,
  input  logic reset,
  output logic scan_tick
);

  // just wide enough for div_count-1
  localparam int cnt_w = $clog2(div_count);

  logic [cnt_w-1:0] count;
  logic             last_count;

  // terminal count of the period
  assign last_count = (count == cnt_w'(div_count - 1));

  // free-running 0 .. div_count-1
  always_ff @(posedge clk_5M) begin
    if (reset) begin
      count <= '0;
    end else if (last_count) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // one-cycle pulse on the last count
  assign scan_tick = last_count;

endmodule

// ==== src/digit_scan_fsm.sv ====
`timescale 1ns/1ns

module digit_scan_fsm (
  input  logic       clk_5M,
  input  logic       reset,
  input  logic       scan_tick,
  output logic [2:0] digit,
  output logic [7:0] an
);

  // one state per anode pattern
  // a single low bit marks the lit digit
  typedef enum logic [7:0] {
    a0 = 8'b1111_1110,
    a1 = 8'b1111_1101,
    a2 = 8'b1111_1011,
    a3 = 8'b1111_0111,
    a4 = 8'b1110_1111,
    a5 = 8'b1101_1111,
    a6 = 8'b1011_1111,
    a7 = 8'b0111_1111
  } an_state_e;

  an_state_e state;
  an_state_e state_nxt;
  // low when the state register holds no known pattern
  logic      legal;

  // step on the tick
  // a bad code is left on the very next edge
  always_ff @(posedge clk_5M) begin
    if (reset) begin
      state <= a0;
    end else if (scan_tick || !legal) begin
      state <= state_nxt;
    end
  end

  // next anode and digit index of the current one
  always_comb begin
    legal = 1'b1;
    case (state)
      a0: begin
        state_nxt = a1;
        digit     = 3'd0;
      end
      a1: begin
        state_nxt = a2;
        digit     = 3'd1;
      end
      a2: begin
        state_nxt = a3;
        digit     = 3'd2;
      end
      a3: begin
        state_nxt = a4;
        digit     = 3'd3;
      end
      a4: begin
        state_nxt = a5;
        digit     = 3'd4;
      end
      a5: begin
        state_nxt = a6;
        digit     = 3'd5;
      end
      a6: begin
        state_nxt = a7;
        digit     = 3'd6;
      end
      a7: begin
        // wrap back to the first digit
        state_nxt = a0;
        digit     = 3'd7;
      end
      default: begin
        // recover to anode 0
        state_nxt = a0;
        digit     = 3'd0;
        legal     = 1'b0;
      end
    endcase
  end

  // state code is the anode drive
  assign an = state;

endmodule

// ==== src/seg_driver.sv ====
`timescale 1ns/1ns

module seg_driver (
  input  logic                 clk_5M,
  input  logic                 reset,
  input  logic                 debug,
  input  logic                 prog,
  input  logic [31:0]          core_debug,
  input  disp_pkg::disp_word_u disp_word,
  input  logic [2:0]           digit,
  output logic [6:0]           sev_out
);
  import disp_pkg::*;

  // word on the display this cycle
  disp_word_u shown_word;
  // hex digit under the lit anode
  logic [3:0] nibble;
  // active-low pattern, segment a in bit 6
  logic [6:0] seg_pattern;

  // core debug word wins in debug or prog mode
  always_comb begin
    if (debug || prog) begin
      shown_word = core_debug;
    end else begin
      shown_word = disp_word;
    end
  end

  assign nibble = shown_word.nibbles[digit];

  // hex to seven segments
  // 0 lights a segment
  always_comb begin
    case (nibble)
      4'h0:    seg_pattern = 7'b0000001;
      4'h1:    seg_pattern = 7'b1001111;
      4'h2:    seg_pattern = 7'b0010010;
      4'h3:    seg_pattern = 7'b0000110;
      4'h4:    seg_pattern = 7'b1001100;
      4'h5:    seg_pattern = 7'b0100100;
      4'h6:    seg_pattern = 7'b0100000;
      4'h7:    seg_pattern = 7'b0001111;
      4'h8:    seg_pattern = 7'b0000000;
      4'h9:    seg_pattern = 7'b0000100;
      4'ha:    seg_pattern = 7'b0001000;
      4'hb:    seg_pattern = 7'b1100000;
      4'hc:    seg_pattern = 7'b0110001;
      4'hd:    seg_pattern = 7'b1000010;
      4'he:    seg_pattern = 7'b0110000;
      4'hf:    seg_pattern = 7'b0111000;
      default: seg_pattern = 7'b1111111;
    endcase
  end

  // pattern lags the anode by one cycle
  // all segments dark while in reset
  always_ff @(posedge clk_5M) begin
    if (reset) begin
      sev_out <= 7'b1111111;
    end else begin
      sev_out <= seg_pattern;
    end
  end

endmodule

// ==== src/disp_top.sv ====
`timescale 1ns/1ns
`include "disp_defines.svh"

module disp_top #(
  // clk_5M cycles per digit
  parameter int div_count = `SCAN_DIV_DEFAULT
) (
  input  logic                clk_5M,
  input  logic                reset,
  input  logic                debug,
  input  logic                prog,
  input  logic [31:0]         core_debug,
  input  logic [4:0]          debug_input,
  input  disp_pkg::mmio_req_t mmio_req,
  output logic [31:0]         mem_dout,
  output logic [15:0]         led,
  output logic [7:0]          an,
  output logic [6:0]          sev_out
);
  import disp_pkg::*;

  // register word toward the segment driver
  disp_word_u disp_word;
  // digit step pulse
  logic       scan_tick;
  // index of the lit digit
  logic [2:0] digit;

  // bus registers
  mmio_regs regs_i (
    .clk_5M      (clk_5M),
    .reset       (reset),
    .mmio_req    (mmio_req),
    .debug_input (debug_input),
    .disp_word   (disp_word),
    .led         (led),
    .mem_dout    (mem_dout)
  );

  // digit pace
  refresh_timer #(
    .div_count (div_count)
  ) timer_i (
    .clk_5M    (clk_5M),
    .reset     (reset),
    .scan_tick (scan_tick)
  );

  // anode rotation
  digit_scan_fsm scan_i (
    .clk_5M    (clk_5M),
    .reset     (reset),
    .scan_tick (scan_tick),
    .digit     (digit),
    .an        (an)
  );

  // source pick and segment pattern
  seg_driver seg_i (
    .clk_5M     (clk_5M),
    .reset      (reset),
    .debug      (debug),
    .prog       (prog),
    .core_debug (core_debug),
    .disp_word  (disp_word),
    .digit      (digit),
    .sev_out    (sev_out)
  );

endmodule

// ==== tests/disp_vectors.svh ====
`ifndef DISP_VECTORS_SVH
`define DISP_VECTORS_SVH

// operation codes for the table
localparam logic [1:0] OP_WRITE = 2'd0;
localparam logic [1:0] OP_READ  = 2'd1;
localparam logic [1:0] OP_SCAN  = 2'd2;
localparam logic [1:0] OP_SRC   = 2'd3;

// one table row
// op, address, lane enables, data, debug, prog, expected read value
// data doubles as the switch setting for SW_ADDR reads
typedef struct packed {
  logic [1:0]  op;
  logic [31:0] addr;
  logic [3:0]  en;
  logic [31:0] data;
  logic        dbg;
  logic        prg;
  logic [31:0] exp;
} vec_t;

localparam int NUM_VEC = 19;

localparam vec_t vec_table [NUM_VEC] = '{
  // reset contents read back as zero
  '{OP_READ,  `DISP_ADDR,    4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000},
  '{OP_READ,  `LED_ADDR,     4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000},
  // full word, then partial lanes
  '{OP_WRITE, `DISP_ADDR,    4'b1111, 32'h1234_5678, 1'b0, 1'b0, 32'h0000_0000},
  '{OP_WRITE, `DISP_ADDR,    4'b0101, 32'hAABB_CCDD, 1'b0, 1'b0, 32'h0000_0000},
  '{OP_WRITE, `DISP_ADDR,    4'b1000, 32'h9F00_0000, 1'b0, 1'b0, 32'h0000_0000},
  '{OP_READ,  `DISP_ADDR,    4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h9FBB_56DD},
  // led takes lanes 0 and 1 only
  '{OP_WRITE, `LED_ADDR,     4'b0011, 32'hFFFF_BEEF, 1'b0, 1'b0, 32'h0000_0000},
  '{OP_WRITE, `LED_ADDR,     4'b0010, 32'h0000_1200, 1'b0, 1'b0, 32'h0000_0000},
  '{OP_READ,  `LED_ADDR,     4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_12EF},
  // unmapped word
  '{OP_WRITE, 32'h0000_040C, 4'b1111, 32'hDEAD_BEEF, 1'b0, 1'b0, 32'h0000_0000},
  '{OP_READ,  32'h0000_040C, 4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000},
  // switches
  '{OP_READ,  `SW_ADDR,      4'b0000, 32'h0000_0016, 1'b0, 1'b0, 32'h0000_0016},
  '{OP_READ,  `DISP_ADDR,    4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h9FBB_56DD},
  // scan the display word
  '{OP_SCAN,  32'h0000_0000, 4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000},
  // core debug word in debug, then prog, then back
  '{OP_SRC,   32'h0000_0000, 4'b0000, 32'h0000_0000, 1'b1, 1'b0, 32'h0000_0000},
  '{OP_SRC,   32'h0000_0000, 4'b0000, 32'h0000_0000, 1'b0, 1'b1, 32'h0000_0000},
  '{OP_SRC,   32'h0000_0000, 4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000},
  // new word, all digits different
  '{OP_WRITE, `DISP_ADDR,    4'b1111, 32'h0FED_CBA9, 1'b0, 1'b0, 32'h0000_0000},
  '{OP_SCAN,  32'h0000_0000, 4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0000_0000}
};

`endif

// ==== tests/disp_tb.sv ====
`timescale 1ns/1ns
`include "disp_defines.svh"

module disp_tb;
  import disp_pkg::*;

  `include "disp_vectors.svh"

  // short scan period keeps runs brief
  localparam int DIV = 4;
  localparam int CLK_PERIOD = 200;

  logic                clk_5M;
  logic                reset;
  logic                debug;
  logic                prog;
  logic [31:0]         core_debug;
  logic [4:0]          debug_input;
  mmio_req_t           mmio_req;
  logic [31:0]         mem_dout;
  logic [15:0]         led;
  logic [7:0]          an;
  logic [6:0]          sev_out;

  // reference copies of the registers
  logic [31:0] disp_model;
  logic [15:0] led_model;
  integer      seed;

  disp_top #(.div_count(DIV)) dut_i (
    .clk_5M      (clk_5M),
    .reset       (reset),
    .debug       (debug),
    .prog        (prog),
    .core_debug  (core_debug),
    .debug_input (debug_input),
    .mmio_req    (mmio_req),
    .mem_dout    (mem_dout),
    .led         (led),
    .an          (an),
    .sev_out     (sev_out)
  );

  initial begin
    clk_5M = 1'b0;
    forever #(CLK_PERIOD / 2) clk_5M = ~clk_5M;
  end

  // run limit from table length
  initial begin
    #((NUM_VEC * (8 * DIV + 20) + 5) * CLK_PERIOD);
    $display("timeout: the table did not finish in the expected time");
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  // compare and stop on mismatch
  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("ERR @%0t: %s expected %h got %h", $time, what, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // active-low hex patterns, segment a in bit 6
  function automatic logic [6:0] hex_segments(input logic [3:0] value);
    case (value)
      4'h0: return 7'b0000001;
      4'h1: return 7'b1001111;
      4'h2: return 7'b0010010;
      4'h3: return 7'b0000110;
      4'h4: return 7'b1001100;
      4'h5: return 7'b0100100;
      4'h6: return 7'b0100000;
      4'h7: return 7'b0001111;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0000100;
      4'ha: return 7'b0001000;
      4'hb: return 7'b1100000;
      4'hc: return 7'b0110001;
      4'hd: return 7'b1000010;
      4'he: return 7'b0110000;
      default: return 7'b0111000;
    endcase
  endfunction

  // index of the single low anode bit
  function automatic int anode_index(input logic [7:0] pattern);
    int idx;
    int zeros;
    idx = 0;
    zeros = 0;
    for (int i = 0; i < 8; i++) begin
      if (pattern[i] === 1'b0) begin
        idx = i;
        zeros++;
      end
    end
    if (zeros != 1) begin
      $display("anode pattern %b does not select exactly one digit", pattern);
      $display("TEST FAILED");
      $fatal(1, "bad anode pattern");
    end
    return idx;
  endfunction

  // word the display should be showing
  function automatic logic [31:0] shown_word();
    return (debug || prog) ? core_debug : disp_model;
  endfunction

  // one full rotation plus the wrap
  // each sample checks the pattern of the digit lit one cycle earlier
  task automatic scan_rotation();
    int prev;
    int idx;
    int changes;
    logic [31:0] word;
    prev = anode_index(an);
    changes = 0;
    word = shown_word();
    while (changes < 9) begin
      @(negedge clk_5M);
      check(sev_out, hex_segments(word[prev*4 +: 4]), "segment pattern");
      idx = anode_index(an);
      if (idx != prev) begin
        check(idx, (prev + 1) % 8, "anode order");
        changes++;
      end
      prev = idx;
    end
  endtask

  task automatic write_entry(input vec_t v);
    mmio_req.wea  = 1'b1;
    mmio_req.en   = v.en;
    mmio_req.addr = v.addr;
    mmio_req.din  = v.data;
    // model the byte lanes
    if (v.addr == `DISP_ADDR) begin
      for (int i = 0; i < 4; i++) begin
        if (v.en[i]) disp_model[i*8 +: 8] = v.data[i*8 +: 8];
      end
    end else if (v.addr == `LED_ADDR) begin
      if (v.en[0]) led_model[7:0] = v.data[7:0];
      if (v.en[1]) led_model[15:8] = v.data[15:8];
    end
    @(negedge clk_5M);
    mmio_req.wea = 1'b0;
    mmio_req.en  = 4'b0000;
    check(led, led_model, "led output");
  endtask

  task automatic read_entry(input vec_t v);
    mmio_req.rea  = 1'b1;
    mmio_req.addr = v.addr;
    if (v.addr == `SW_ADDR) debug_input = v.data[4:0];
    @(negedge clk_5M);
    mmio_req.rea = 1'b0;
    check(mem_dout, v.exp, "read data");
    if (v.addr == `DISP_ADDR) check(mem_dout, disp_model, "display model");
  endtask

  // switch the source, check the next cycle, then scan
  task automatic source_entry(input vec_t v);
    int idx;
    logic [31:0] word;
    idx = anode_index(an);
    debug = v.dbg;
    prog = v.prg;
    core_debug = $random(seed);
    word = shown_word();
    @(negedge clk_5M);
    check(sev_out, hex_segments(word[idx*4 +: 4]), "source switch");
    scan_rotation();
  endtask

  initial begin
    seed = 19;
    reset = 1'b1;
    debug = 1'b0;
    prog = 1'b0;
    core_debug = '0;
    debug_input = '0;
    mmio_req = '0;
    disp_model = '0;
    led_model = '0;
    repeat (5) @(negedge clk_5M);
    reset = 1'b0;
    // state right after reset
    check(an, 8'hFE, "anode after reset");
    check(sev_out, 7'h7F, "blank segments after reset");
    check(led, 16'h0000, "led after reset");
    check(mem_dout, 32'h0000_0000, "load data after reset");
    for (int n = 0; n < NUM_VEC; n++) begin
      case (vec_table[n].op)
        OP_WRITE: write_entry(vec_table[n]);
        OP_READ:  read_entry(vec_table[n]);
        OP_SCAN:  scan_rotation();
        default:  source_entry(vec_table[n]);
      endcase
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+src
+incdir+tests
src/disp_pkg.sv
src/mmio_regs.sv
src/refresh_timer.sv
src/digit_scan_fsm.sv
src/seg_driver.sv
src/disp_top.sv
tests/disp_tb.sv

// ==== Bender.yml ====
package:
  name: disp_mmio

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/disp_pkg.sv
      - src/mmio_regs.sv
      - src/refresh_timer.sv
      - src/digit_scan_fsm.sv
      - src/seg_driver.sv
      - src/disp_top.sv

  - target: test
    include_dirs:
      - src
      - tests
    files:
      - tests/disp_tb.sv
